//--- list.f
+incdir+rtl
+incdir+tb
rtl/shaPkg.sv
rtl/serialPkg.sv
rtl/sha256Compress.sv
rtl/nonceSearch.sv
rtl/uartRx.sv
rtl/uartTx.sv
rtl/jobFramer.sv
rtl/minerTop.sv
tb/minerTb.sv

//--- Makefile
TOP = minerTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

# Pass is decided by the log, not the exit status of the run
sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/minerRefModel.svh
`ifndef MINER_REF_MODEL_SVH
`define MINER_REF_MODEL_SVH

// SHA-256 round constants
localparam logic [31:0] roundK [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

function automatic logic [31:0] rotateRight(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
endfunction

// One compression, whole schedule expanded up front
function automatic hashState compress(input hashState iv, input msgBlock blk);
    logic [31:0] w [64];
    logic [31:0] v [8];
    logic [31:0] t1;
    logic [31:0] t2;
    hashState    sum;
    for (int t = 0; t < 16; t++) begin
        w[t] = blk[15 - t];
    end
    for (int t = 16; t < 64; t++) begin
        w[t] = (rotateRight(w[t-2], 17) ^ rotateRight(w[t-2], 19) ^ (w[t-2] >> 10)) + w[t-7]
            + (rotateRight(w[t-15], 7) ^ rotateRight(w[t-15], 18) ^ (w[t-15] >> 3)) + w[t-16];
    end
    // v[0] is a, v[7] is h
    for (int i = 0; i < 8; i++) begin
        v[i] = iv[7 - i];
    end
    for (int t = 0; t < 64; t++) begin
        t1 = v[7] + (rotateRight(v[4], 6) ^ rotateRight(v[4], 11) ^ rotateRight(v[4], 25))
            + ((v[4] & v[5]) ^ (~v[4] & v[6])) + roundK[t] + w[t];
        t2 = (rotateRight(v[0], 2) ^ rotateRight(v[0], 13) ^ rotateRight(v[0], 22))
            + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
        for (int i = 7; i > 0; i--) begin
            v[i] = v[i - 1];
        end
        v[4] = v[4] + t1;
        v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) begin
        sum[7 - i] = iv[7 - i] + v[i];
    end
    return sum;
endfunction

// Tail, nonce in header byte order, padding for an 80-byte message
function automatic msgBlock paddedBlock(input logic [95:0] tail, input logic [31:0] nonce);
    msgBlock blk;
    blk = '0;
    blk[15:13] = tail;
    blk[12] = {nonce[7:0], nonce[15:8], nonce[23:16], nonce[31:24]};
    blk[11] = 32'h8000_0000;
    // Length in bits
    blk[0] = 32'd640;
    return blk;
endfunction

function automatic int leadingZeros(input logic [63:0] v);
    int n;
    n = 0;
    while (n < 64 && !v[63 - n]) begin
        n++;
    end
    return n;
endfunction

// Scan from nonce zero, first qualifying nonce or the last one tried
function automatic searchResult searchModel(input miningJob j);
    searchResult r;
    hashState    d;
    int          need;
    r.found = 1'b0;
    r.nonce = 32'(`NONCE_LIMIT - 1);
    if (j.difficulty > 8'd64) need = 64;
    else need = int'(j.difficulty);
    for (int n = 0; n < `NONCE_LIMIT && !r.found; n++) begin
        d = compress(j.midstate, paddedBlock(j.tail, 32'(n)));
        if (leadingZeros({d[7], d[6]}) >= need) begin
            r.found = 1'b1;
            r.nonce = 32'(n);
        end
    end
    return r;
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

`endif

//--- tb/minerTb.sv
`default_nettype none
`include "miner_consts.svh"

module minerTb;
    import shaPkg::*;
    import serialPkg::*;

    `include "minerRefModel.svh"

    typedef enum logic [1:0] {
        PLAIN,
        INTERRUPTED,
        AFTER_PARTIAL
    } jobKind;

    typedef struct packed {
        miningJob    job;
        jobKind      kind;
        searchResult expected;
    } tableEntry;

    localparam int numEntries = 5;
    // Start, data and stop bits plus a spare cycle per byte, with slack
    localparam int frameCycles = `JOB_BYTES * 11 * `CLKS_PER_BIT;
    localparam int searchCycles = `NONCE_LIMIT * 66;
    localparam int quietCycles = 2 * `REPLY_BYTES * 10 * `CLKS_PER_BIT;

    logic        clock;
    logic        rstN;
    logic        rxd;
    logic        txd;
    logic        replyAllowed;
    logic        txdLast = 1'b1;
    logic [31:0] rngState;
    int          checkCount;
    int          errorCount;
    int          lineErrors;
    tableEntry   jobs [numEntries];
    string       notes [numEntries];

    minerTop uut (
        .clock (clock),
        .rstN  (rstN),
        .rxd   (rxd),
        .txd   (txd)
    );

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic miningJob randomJob(input logic [7:0] difficulty);
        miningJob j;
        for (int i = 7; i >= 0; i--) begin
            j.midstate[i] = nextRandom();
        end
        for (int i = 2; i >= 0; i--) begin
            j.tail[32 * i +: 32] = nextRandom();
        end
        j.difficulty = difficulty;
        return j;
    endfunction

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clock);
        #2;
    endtask

    // One UART bit, entered just after a rising edge
    task automatic driveBit(input logic value);
        rxd = value;
        repeat (`CLKS_PER_BIT) @(posedge clock);
        #2;
    endtask

    task automatic sendByte(input logic [7:0] data);
        waitCycles(1);
        driveBit(1'b0);
        for (int i = 0; i < 8; i++) begin
            driveBit(data[i]);
        end
        driveBit(1'b1);
    endtask

    // First count bytes of a frame, top byte first
    task automatic sendFrame(input miningJob j, input int count);
        for (int i = 0; i < count; i++) begin
            sendByte(j[$bits(miningJob) - 1 - 8 * i -: 8]);
        end
    endtask

    // Samples txd on falling edges, halfway into each bit
    task automatic receiveReply(input int limit, output logic [7:0] status,
                                output logic [31:0] nonce, output bit ok);
        logic [7:0] frame [`REPLY_BYTES];
        int         waited;
        ok = 1'b0;
        status = '0;
        nonce = '0;
        for (int k = 0; k < `REPLY_BYTES; k++) begin
            waited = 0;
            while (txd !== 1'b0 && waited < (k == 0 ? limit : 4 * `CLKS_PER_BIT)) begin
                @(negedge clock);
                waited++;
            end
            assert (txd === 1'b0) else begin
                $display("Timeout: reply byte %0d never started", k);
                errorCount++;
            end
            if (txd !== 1'b0) return;
            repeat (`CLKS_PER_BIT / 2) @(negedge clock);
            assert (txd === 1'b0) else begin
                $display("Reply byte %0d start bit did not stay low", k);
                errorCount++;
            end
            for (int b = 0; b < 8; b++) begin
                repeat (`CLKS_PER_BIT) @(negedge clock);
                frame[k][b] = txd;
            end
            repeat (`CLKS_PER_BIT) @(negedge clock);
            assert (txd === 1'b1) else begin
                $display("Reply byte %0d has a low stop bit", k);
                errorCount++;
            end
        end
        status = frame[0];
        nonce = {frame[4], frame[3], frame[2], frame[1]};
        ok = 1'b1;
    endtask

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Start bit outside a reply window, reported once per edge
    always @(negedge clock) begin
        if (rstN && !replyAllowed && txdLast) begin
            assert (txd === 1'b1) else begin
                $display("CHECK FAILED txd: expected %h got %h with no reply due", 1'b1, txd);
                lineErrors++;
            end
        end
        txdLast = txd;
    end

    initial begin
        repeat (numEntries * (3 * frameCycles + searchCycles + quietCycles + 4000))
            @(posedge clock);
        $display("Watchdog: the run did not finish in the expected time");
        $display("Checks: %0d, reply errors: %0d, line errors: %0d",
                 checkCount, errorCount, lineErrors);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [7:0]  status;
        logic [31:0] nonce;
        bit          ok;
        rstN = 1'b0;
        rxd = 1'b1;
        replyAllowed = 1'b0;
        rngState = 32'd35813;
        checkCount = 0;
        errorCount = 0;
        lineErrors = 0;
        // Fixed job, every digest qualifies
        jobs[0].job.midstate = {32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
                                32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};
        jobs[0].job.tail = 96'h4d696e65_72546573_744a6f62;
        jobs[0].job.difficulty = 8'd0;
        jobs[0].kind = PLAIN;
        notes[0] = "difficulty 0";
        jobs[1].job = randomJob(8'd8);
        jobs[1].kind = PLAIN;
        notes[1] = "difficulty 8, random job";
        jobs[2].job = randomJob(8'd40);
        jobs[2].kind = PLAIN;
        notes[2] = "difficulty 40, exhausted";
        jobs[3].job = randomJob(8'd6);
        jobs[3].kind = INTERRUPTED;
        notes[3] = "second job restarts search";
        jobs[4].job = randomJob(8'd4);
        jobs[4].kind = AFTER_PARTIAL;
        notes[4] = "partial frame dropped";
        for (int i = 0; i < numEntries; i++) begin
            jobs[i].expected = searchModel(jobs[i].job);
        end

        repeat (16) @(posedge clock);
        #2;
        rstN = 1'b1;
        // Idle line, no reply expected yet
        waitCycles(200);

        for (int i = 0; i < numEntries; i++) begin
            case (jobs[i].kind)
                INTERRUPTED: begin
                    // Long search, cut short by the table job
                    sendFrame(randomJob(8'd40), `JOB_BYTES);
                    waitCycles(1000);
                end
                AFTER_PARTIAL: begin
                    sendFrame(randomJob(8'd0), 20);
                    waitCycles(12 * `CLKS_PER_BIT);
                end
                default: ;
            endcase
            sendFrame(jobs[i].job, `JOB_BYTES);
            replyAllowed = 1'b1;
            receiveReply(searchCycles + 2000, status, nonce, ok);
            replyAllowed = 1'b0;
            if (ok) begin
                checkCount += 2;
                assert (status === {7'd0, jobs[i].expected.found}) else begin
                    $display("CHECK FAILED entry %0d (%s): reply status expected %h got %h",
                             i, notes[i], {7'd0, jobs[i].expected.found}, status);
                    errorCount++;
                end
                assert (nonce === jobs[i].expected.nonce) else begin
                    $display("CHECK FAILED entry %0d (%s): reply nonce expected %h got %h",
                             i, notes[i], jobs[i].expected.nonce, nonce);
                    errorCount++;
                end
            end
            // Any second reply shows up as a line error here
            waitCycles(quietCycles);
        end

        $display("Checks: %0d, reply errors: %0d, line errors: %0d",
                 checkCount, errorCount, lineErrors);
        if (errorCount == 0 && lineErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/minerTop.sv
`default_nettype none

module minerTop (
    input  logic clock,
    input  logic rstN,
    input  logic rxd,
    output logic txd
);
    import shaPkg::*;
    import serialPkg::*;

    // Receive path
    logic [7:0]  rxByte;
    logic        rxValid;

    // Job handoff to the search
    miningJob    job;
    logic        jobStart;

    // Hash core
    logic        hashStart;
    logic        hashDone;
    hashState    initState;
    hashState    digest;
    msgBlock     block;

    // Reply path
    searchResult result;
    logic        resultValid;
    logic [7:0]  txByte;
    logic        txStart;
    logic        txBusy;

    uartRx uRx (
        .clock   (clock),
        .rstN    (rstN),
        .rxd     (rxd),
        .rxByte  (rxByte),
        .rxValid (rxValid)
    );

    jobFramer uFramer (
        .clock       (clock),
        .rstN        (rstN),
        .rxByte      (rxByte),
        .rxValid     (rxValid),
        .job         (job),
        .jobStart    (jobStart),
        .result      (result),
        .resultValid (resultValid),
        .txByte      (txByte),
        .txStart     (txStart),
        .txBusy      (txBusy)
    );

    nonceSearch uSearch (
        .clock       (clock),
        .rstN        (rstN),
        .job         (job),
        .jobStart    (jobStart),
        .hashStart   (hashStart),
        .initState   (initState),
        .block       (block),
        .hashDone    (hashDone),
        .digest      (digest),
        .result      (result),
        .resultValid (resultValid)
    );

    sha256Compress uHash (
        .clock     (clock),
        .rstN      (rstN),
        .hashStart (hashStart),
        .initState (initState),
        .block     (block),
        .hashDone  (hashDone),
        .digest    (digest)
    );

    uartTx uTx (
        .clock   (clock),
        .rstN    (rstN),
        .txByte  (txByte),
        .txStart (txStart),
        .txd     (txd),
        .txBusy  (txBusy)
    );

endmodule

`default_nettype wire

//--- rtl/jobFramer.sv
`default_nettype none
`include "miner_consts.svh"

module jobFramer (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic [7:0]             rxByte,
    input  logic                   rxValid,
    output serialPkg::miningJob    job,
    output logic                   jobStart,
    input  serialPkg::searchResult result,
    input  logic                   resultValid,
    output logic [7:0]             txByte,
    output logic                   txStart,
    input  logic                   txBusy
);
    import serialPkg::*;

    logic [`JOB_BYTES*8-1:0] frame;
    logic [5:0]              byteCount;
    logic [5:0]              curCount;
    logic [15:0]             idleCnt;
    logic                    stale;
    searchResult             reply;
    logic                    sending;
    logic [2:0]              txIdx;

    assign job = frame;

    // Twelve silent bit-times, longer than one byte time
    assign stale = idleCnt >= 16'(12 * `CLKS_PER_BIT);
    // Byte after a stale gap starts a new frame
    assign curCount = stale ? 6'd0 : byteCount;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            byteCount <= '0;
            idleCnt <= '0;
            jobStart <= 1'b0;
        end else begin
            jobStart <= 1'b0;
            if (!stale) idleCnt <= idleCnt + 16'd1;
            if (rxValid) begin
                idleCnt <= '0;
                if (curCount == 6'(`JOB_BYTES - 1)) begin
                    byteCount <= '0;
                    jobStart <= 1'b1;
                end else begin
                    byteCount <= curCount + 6'd1;
                end
            end
        end
    end

    // First byte ends up in the top of the frame
    always_ff @(posedge clock) begin
        if (rxValid) frame <= {frame[`JOB_BYTES*8-9:0], rxByte};
    end

    // Status byte first, then nonce LSB first
    always_comb begin
        case (txIdx)
            3'd0: txByte = {7'd0, reply.found};
            3'd1: txByte = reply.nonce[7:0];
            3'd2: txByte = reply.nonce[15:8];
            3'd3: txByte = reply.nonce[23:16];
            default: txByte = reply.nonce[31:24];
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            sending <= 1'b0;
            txStart <= 1'b0;
            txIdx <= '0;
        end else begin
            txStart <= 1'b0;
            if (!sending) begin
                txIdx <= '0;
                if (resultValid) sending <= 1'b1;
            end else if (txStart) begin
                // Byte taken by the transmitter, move on
                txIdx <= txIdx + 3'd1;
                if (txIdx == 3'(`REPLY_BYTES - 1)) sending <= 1'b0;
            end else if (!txBusy) begin
                txStart <= 1'b1;
            end
        end
    end

    // Result during a reply in progress is dropped
    always_ff @(posedge clock) begin
        if (resultValid && !sending) reply <= result;
    end

endmodule

`default_nettype wire

//--- rtl/uartTx.sv
`default_nettype none
`include "miner_consts.svh"

module uartTx (
    input  logic       clock,
    input  logic       rstN,
    input  logic [7:0] txByte,
    input  logic       txStart,
    output logic       txd,
    output logic       txBusy
);
    import serialPkg::*;

    uartState   state;
    logic [7:0] count;
    logic [2:0] bitIdx;
    logic [7:0] shifter;

    // Busy already in the txStart cycle
    assign txBusy = txStart || (state != IDLE);

    always_comb begin
        case (state)
            START: txd = 1'b0;
            DATA: txd = shifter[0];
            // Idle and stop bit are high
            default: txd = 1'b1;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= IDLE;
            count <= '0;
            bitIdx <= '0;
        end else begin
            count <= count + 8'd1;
            case (state)
                IDLE: begin
                    count <= '0;
                    bitIdx <= '0;
                    if (txStart) begin
                        shifter <= txByte;
                        state <= START;
                    end
                end
                START: begin
                    if (count == 8'(`CLKS_PER_BIT - 1)) begin
                        count <= '0;
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (count == 8'(`CLKS_PER_BIT - 1)) begin
                        count <= '0;
                        shifter <= shifter >> 1;
                        bitIdx <= bitIdx + 3'd1;
                        if (bitIdx == 3'd7) state <= STOP;
                    end
                end
                STOP: begin
                    if (count == 8'(`CLKS_PER_BIT - 1)) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/uartRx.sv
`default_nettype none
`include "miner_consts.svh"

module uartRx (
    input  logic       clock,
    input  logic       rstN,
    input  logic       rxd,
    output logic [7:0] rxByte,
    output logic       rxValid
);
    import serialPkg::*;

    uartState   state;
    // Two-flop synchronizer, idles high like the line
    logic       rxMeta;
    logic       rxSync;
    logic [7:0] count;
    logic [2:0] bitIdx;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            state <= IDLE;
            count <= '0;
            bitIdx <= '0;
            rxValid <= 1'b0;
        end else begin
            rxMeta <= rxd;
            rxSync <= rxMeta;
            rxValid <= 1'b0;
            count <= count + 8'd1;
            case (state)
                IDLE: begin
                    count <= '0;
                    if (!rxSync) state <= START;
                end
                START: begin
                    // Mid start bit, still low or it was a glitch
                    if (count == 8'(`CLKS_PER_BIT / 2 - 1)) begin
                        count <= '0;
                        bitIdx <= '0;
                        state <= rxSync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    // One full bit later is mid data bit, LSB first
                    if (count == 8'(`CLKS_PER_BIT - 1)) begin
                        count <= '0;
                        rxByte <= {rxSync, rxByte[7:1]};
                        bitIdx <= bitIdx + 3'd1;
                        if (bitIdx == 3'd7) state <= STOP;
                    end
                end
                STOP: begin
                    if (count == 8'(`CLKS_PER_BIT - 1)) begin
                        // Low stop bit is a framing error, byte dropped
                        rxValid <= rxSync;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/nonceSearch.sv
`default_nettype none
`include "miner_consts.svh"

module nonceSearch (
    input  logic                   clock,
    input  logic                   rstN,
    input  serialPkg::miningJob    job,
    input  logic                   jobStart,
    output logic                   hashStart,
    output shaPkg::hashState       initState,
    output shaPkg::msgBlock        block,
    input  logic                   hashDone,
    input  shaPkg::hashState       digest,
    output serialPkg::searchResult result,
    output logic                   resultValid
);
    import shaPkg::*;

    searchState  state;
    // Latched job
    hashState    midstate;
    logic [95:0] tail;
    logic [7:0]  difficulty;
    logic [31:0] nonce;
    logic [31:0] nonceSwap;
    logic        stop;
    logic        hit;
    logic [6:0]  zeros;
    logic [6:0]  need;
    logic        accept;
    logic        lastNonce;

    // Leading zero bits of a 64-bit value
    function automatic logic [6:0] leadZeros(input logic [63:0] v);
        logic [6:0] n;
        logic       seen;
        n = 7'd0;
        seen = 1'b0;
        for (int i = 63; i >= 0; i--) begin
            if (v[i]) seen = 1'b1;
            else if (!seen) n = n + 7'd1;
        end
        return n;
    endfunction

    // Nonce goes into the header little endian
    assign nonceSwap = {nonce[7:0], nonce[15:8], nonce[23:16], nonce[31:24]};

    // Tail, nonce, pad bit, zeros, 640-bit message length
    assign block = {tail, nonceSwap, 32'h8000_0000, 320'd0, 32'd640};
    assign initState = midstate;

    // Leading zeros run across word a into word b
    assign zeros = leadZeros({digest[7], digest[6]});
    assign need = (difficulty > 8'd64) ? 7'd64 : difficulty[6:0];
    assign accept = zeros >= need;
    assign lastNonce = nonce == 32'(`NONCE_LIMIT - 1);

    // CHECK issues the next hash unless the search is over
    assign hashStart = (state == CHECK) && !stop;
    assign resultValid = state == REPORT;
    assign result = {hit, nonce};

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= IDLE;
            stop <= 1'b0;
        end else if (jobStart) begin
            // New job wins in any state
            state <= CHECK;
            stop <= 1'b0;
            nonce <= '0;
        end else begin
            case (state)
                HASHING: begin
                    if (hashDone) begin
                        hit <= accept;
                        // Keep the last tried nonce for the reply
                        if (accept || lastNonce) stop <= 1'b1;
                        else nonce <= nonce + 32'd1;
                        state <= CHECK;
                    end
                end
                CHECK: state <= stop ? REPORT : HASHING;
                REPORT: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (jobStart) begin
            midstate <= job.midstate;
            tail <= job.tail;
            difficulty <= job.difficulty;
        end
    end

endmodule

`default_nettype wire

//--- rtl/sha256Compress.sv
`default_nettype none

module sha256Compress (
    input  logic             clock,
    input  logic             rstN,
    input  logic             hashStart,
    input  shaPkg::hashState initState,
    input  shaPkg::msgBlock  block,
    output logic             hashDone,
    output shaPkg::hashState digest
);
    import shaPkg::*;

    // SHA-256 round constants
    localparam logic [31:0] K [64] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    hashState    init;
    hashState    work;
    // Rolling schedule window, w[15] is the word for this round
    msgBlock     w;
    logic [6:0]  round;
    logic        busy;
    logic [31:0] a, b, c, d, e, f, g, h;
    logic [31:0] t1;
    logic [31:0] t2;
    logic [31:0] s0;
    logic [31:0] s1;
    logic [31:0] nextW;

    function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    assign {a, b, c, d, e, f, g, h} = work;

    // Round 64 means all rounds are in
    assign hashDone = busy && (round == 7'd64);

    always_comb begin
        t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g))
            + K[round[5:0]] + w[15];
        t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
        // W[t+16] from W[t], W[t+1], W[t+9], W[t+14]
        s0 = rotr(w[14], 7) ^ rotr(w[14], 18) ^ (w[14] >> 3);
        s1 = rotr(w[1], 17) ^ rotr(w[1], 19) ^ (w[1] >> 10);
        nextW = s1 + w[6] + s0 + w[15];
    end

    // Feed-forward sum, valid while hashDone is high
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            digest[i] = init[i] + work[i];
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            busy <= 1'b0;
            round <= '0;
        end else if (hashStart) begin
            busy <= 1'b1;
            round <= '0;
        end else if (busy) begin
            // Done cycle ends the run
            if (round == 7'd64) busy <= 1'b0;
            else round <= round + 7'd1;
        end
    end

    // Datapath, restarted by hashStart at any time
    always_ff @(posedge clock) begin
        if (hashStart) begin
            init <= initState;
            work <= initState;
            w <= block;
        end else if (busy && round != 7'd64) begin
            work <= {t1 + t2, a, b, c, d + t1, e, f, g};
            w <= {w[14:0], nextW};
        end
    end

endmodule

`default_nettype wire

//--- rtl/serialPkg.sv
`default_nettype none

package serialPkg;

    // Shared by receiver and transmitter
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uartState;

    // First received byte lands in the top of the frame
    typedef struct packed {
        shaPkg::hashState midstate;
        logic [95:0]      tail;
        logic [7:0]       difficulty;
    } miningJob;

    typedef struct packed {
        logic        found;
        logic [31:0] nonce;
    } searchResult;

endpackage

`default_nettype wire

//--- rtl/shaPkg.sv
`default_nettype none

package shaPkg;

    // Working variables, word a in the top 32 bits
    typedef logic [7:0][31:0] hashState;

    // Message block, word 0 in the top 32 bits
    typedef logic [15:0][31:0] msgBlock;

    // Nonce search FSM
    typedef enum logic [1:0] {
        IDLE,
        HASHING,
        CHECK,
        REPORT
    } searchState;

endpackage

`default_nettype wire

//--- rtl/miner_consts.svh
`ifndef MINER_CONSTS_SVH
`define MINER_CONSTS_SVH

// UART bit period in clocks, kept short for fast simulation
`define CLKS_PER_BIT 8

// Job frame: 32-byte midstate, 12-byte tail, difficulty byte
`define JOB_BYTES 45

// Reply frame: status byte then nonce, LSB first
`define REPLY_BYTES 5

// Nonces tried before the search gives up
`define NONCE_LIMIT 4096

`endif
